/* Bender.yml */
package:
  name: ifetch

sources:
  - source/fetch_pkg.sv
  - source/line_reader.sv
  - source/icache.sv
  - source/parcel_aligner.sv
  - source/fetch_control.sv
  - source/ifetch_top.sv
  - target: simulation
    files:
      - verif/mem_model.sv
      - verif/tb_ifetch.sv

/* list.f */
source/fetch_pkg.sv
source/line_reader.sv
source/icache.sv
source/parcel_aligner.sv
source/fetch_control.sv
source/ifetch_top.sv
verif/mem_model.sv
verif/tb_ifetch.sv

/* source/fetch_control.sv */
`timescale 1ns/1ns

module fetch_control import fetch_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   flush,
    input  addr_t                  flush_pc,
    input  logic                   out_ready,
    output logic                   out_valid,
    output instr_t                 out_instr,
    output addr_t                  out_addr,
    output addr_t                  out_next_addr,
    output logic                   out_exception,
    output line_addr_t             lk_line,
    input  logic                   hit,
    input  line_t                  hit_data,
    output logic                   wr_en,
    output line_addr_t             wr_line,
    output line_t                  wr_data,
    output logic                   rd_req,
    output line_addr_t             rd_line,
    input  logic                   rd_busy,
    input  logic                   rd_done,
    input  line_t                  rd_data,
    output line_t                  aln_line,
    output logic [OFFSET_BITS-1:0] aln_offset,
    input  logic                   is_compressed,
    input  logic                   crosses_line,
    input  logic                   bad_length,
    input  instr_t                 aln_instr,
    input  logic [OFFSET_BITS-1:0] next_offset,
    input  logic                   next_on_next_line
);

    typedef enum logic [2:0] {
        S_LOOKUP,   // Hit result for the line of pc is due
        S_READ,     // First line missed, waiting for the bus
        S_LOOKUP2,  // Hit result for next_line is due, low parcel is held
        S_READ2,
        S_HALT      // Idle after reset or an illegal length, until a redirect
    } state_t;

    state_t     state, state_d;
    addr_t      pc, pc_d;
    line_addr_t pc_line;
    line_addr_t next_line, next_line_d;  // Line after the one pc points into
    parcel_t    lo_q;
    parcel_t    hi_parcel;
    logic       can_emit;
    logic       first_ok;
    logic       emit, emit_exc;
    instr_t     emit_instr;
    addr_t      emit_next;
    addr_t      step_pc;

    assign pc_line    = pc[ALEN-1:OFFSET_BITS];
    assign can_emit   = !out_valid || out_ready;
    assign aln_line   = (state == S_READ) ? rd_data : hit_data;
    assign aln_offset = pc[OFFSET_BITS-1:0];
    assign step_pc    = {(next_on_next_line ? next_line : pc_line), next_offset};
    assign hi_parcel  = (state == S_READ2) ? rd_data[PARCEL_W-1:0] : hit_data[PARCEL_W-1:0];

    // First parcel available, from the cache or straight from the bus
    assign first_ok = (state == S_LOOKUP && can_emit && hit) || (state == S_READ && rd_done);

    assign rd_line = (state == S_READ2) ? next_line : pc_line;
    assign rd_req  = (state == S_READ || state == S_READ2) && !rd_busy && !flush;
    assign wr_en   = rd_done;
    assign wr_line = rd_line;
    assign wr_data = rd_data;

    always_comb begin
        state_d     = state;
        pc_d        = pc;
        next_line_d = next_line;
        lk_line     = (state == S_LOOKUP2 || state == S_READ2) ? next_line : pc_line;
        emit        = 1'b0;
        emit_exc    = bad_length;
        emit_instr  = is_compressed ? {{(ILEN-PARCEL_W){1'b0}}, aln_instr[PARCEL_W-1:0]}
                                    : aln_instr;
        emit_next   = step_pc;
        if (flush) begin
            state_d     = S_LOOKUP;
            pc_d        = flush_pc;
            next_line_d = flush_pc[ALEN-1:OFFSET_BITS] + 1'b1;
            lk_line     = flush_pc[ALEN-1:OFFSET_BITS];
        end else begin
            case (state)
                S_LOOKUP, S_READ: begin
                    if (first_ok) begin
                        if (bad_length) begin
                            emit    = 1'b1;
                            state_d = S_HALT;
                        end else if (crosses_line) begin
                            state_d = S_LOOKUP2;  // pc stays on the first line
                            lk_line = next_line;
                        end else begin
                            emit    = 1'b1;
                            state_d = S_LOOKUP;
                            pc_d    = step_pc;
                            lk_line = step_pc[ALEN-1:OFFSET_BITS];
                            if (next_on_next_line) begin
                                next_line_d = next_line + 1'b1;
                            end
                        end
                    end else if (state == S_LOOKUP && can_emit) begin
                        state_d = S_READ;  // Miss
                    end
                end
                S_LOOKUP2, S_READ2: begin
                    if ((state == S_LOOKUP2 && hit) || (state == S_READ2 && rd_done)) begin
                        emit        = 1'b1;
                        emit_exc    = 1'b0;
                        emit_instr  = {hi_parcel, lo_q};
                        emit_next   = {next_line, OFFSET_BITS'(ILEN/8 - PARCEL_W/8)};
                        state_d     = S_LOOKUP;
                        pc_d        = emit_next;
                        next_line_d = next_line + 1'b1;
                    end else if (state == S_LOOKUP2) begin
                        state_d = S_READ2;
                    end
                end
                default: state_d = S_HALT;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= S_HALT;
            out_valid <= 1'b0;
        end else begin
            state <= state_d;
            if (flush) begin
                out_valid <= 1'b0;
            end else if (emit) begin
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;  // Accepted with nothing new behind it
            end
        end
    end

    always_ff @(posedge clk) begin
        pc        <= pc_d;
        next_line <= next_line_d;
        if (state_d == S_LOOKUP2) begin
            lo_q <= aln_instr[PARCEL_W-1:0];
        end
        if (emit) begin
            out_instr     <= emit_instr;
            out_addr      <= pc;
            out_next_addr <= emit_next;
            out_exception <= emit_exc;
        end
    end

endmodule

/* source/fetch_pkg.sv */
package fetch_pkg;

    localparam int ALEN = 32;       // Fetch address width
    localparam int ILEN = 32;       // Widest instruction the decoder takes
    localparam int PARCEL_W = 16;   // Instructions are built from 16-bit parcels
    localparam int LINE_W = 64;

    // A fetch address splits into tag, index and byte offset
    localparam int OFFSET_BITS = 3;
    localparam int INDEX_BITS = 6;
    localparam int TAG_BITS = ALEN - INDEX_BITS - OFFSET_BITS;
    localparam int LINE_ADDR_W = ALEN - OFFSET_BITS;

    localparam int NUM_LINES = 1 << INDEX_BITS;
    localparam int PARCELS_PER_LINE = LINE_W / PARCEL_W;

    typedef logic [ALEN-1:0] addr_t;
    typedef logic [LINE_ADDR_W-1:0] line_addr_t;  // Fetch address without its offset
    typedef logic [LINE_W-1:0] line_t;
    typedef logic [ILEN-1:0] instr_t;
    typedef logic [PARCEL_W-1:0] parcel_t;

endpackage

/* source/icache.sv */
`timescale 1ns/1ns

module icache import fetch_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  line_addr_t lk_line,
    output logic       hit,
    output line_t      hit_data,
    input  logic       wr_en,
    input  line_addr_t wr_line,
    input  line_t      wr_data
);

    line_t                 data_mem [NUM_LINES];
    logic [TAG_BITS-1:0]   tag_mem  [NUM_LINES];
    logic [NUM_LINES-1:0]  valid;

    logic [INDEX_BITS-1:0] lk_index;
    logic [INDEX_BITS-1:0] wr_index;
    logic [TAG_BITS-1:0]   lk_tag;
    logic                  fwd;

    assign lk_index = lk_line[INDEX_BITS-1:0];
    assign lk_tag   = lk_line[LINE_ADDR_W-1:INDEX_BITS];
    assign wr_index = wr_line[INDEX_BITS-1:0];

    // A line written in the lookup cycle counts as present, so the fetch
    // can continue in the line that just came off the bus without a bubble
    assign fwd = wr_en && wr_line == lk_line;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            data_mem[wr_index] <= wr_data;
            tag_mem[wr_index]  <= wr_line[LINE_ADDR_W-1:INDEX_BITS];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
        end else if (wr_en) begin
            valid[wr_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hit <= 1'b0;
        end else begin
            hit <= fwd || (valid[lk_index] && tag_mem[lk_index] == lk_tag);
        end
    end

    always_ff @(posedge clk) begin
        hit_data <= fwd ? wr_data : data_mem[lk_index];
    end

endmodule

/* source/ifetch_top.sv */
`timescale 1ns/1ns

module ifetch_top import fetch_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   flush,
    input  addr_t  flush_pc,
    output logic   out_valid,
    input  logic   out_ready,
    output instr_t out_instr,
    output addr_t  out_addr,
    output addr_t  out_next_addr,
    output logic   out_exception,
    output logic   ar_valid,
    input  logic   ar_ready,
    output addr_t  ar_addr,
    input  logic   r_valid,
    output logic   r_ready,
    input  line_t  r_data
);

    line_addr_t             lk_line;
    logic                   hit;
    line_t                  hit_data;
    logic                   wr_en;
    line_addr_t             wr_line;
    line_t                  wr_data;
    logic                   rd_req;
    line_addr_t             rd_line;
    logic                   rd_busy;
    logic                   rd_done;
    line_t                  rd_data;
    line_t                  aln_line;
    logic [OFFSET_BITS-1:0] aln_offset;
    logic                   is_compressed;
    logic                   crosses_line;
    logic                   bad_length;
    instr_t                 aln_instr;
    logic [OFFSET_BITS-1:0] next_offset;
    logic                   next_on_next_line;

    line_reader reader_i (
        .clk, .rst, .flush,
        .rd_req, .rd_line, .rd_busy, .rd_done, .rd_data,
        .ar_valid, .ar_addr, .ar_ready,
        .r_valid, .r_data, .r_ready
    );

    icache cache_i (
        .clk, .rst,
        .lk_line, .hit, .hit_data,
        .wr_en, .wr_line, .wr_data
    );

    parcel_aligner aligner_i (
        .line   (aln_line),
        .offset (aln_offset),
        .is_compressed, .crosses_line, .bad_length,
        .instr  (aln_instr),
        .next_offset, .next_on_next_line
    );

    fetch_control control_i (
        .clk, .rst, .flush, .flush_pc,
        .out_ready, .out_valid, .out_instr, .out_addr, .out_next_addr, .out_exception,
        .lk_line, .hit, .hit_data,
        .wr_en, .wr_line, .wr_data,
        .rd_req, .rd_line, .rd_busy, .rd_done, .rd_data,
        .aln_line, .aln_offset,
        .is_compressed, .crosses_line, .bad_length, .aln_instr,
        .next_offset, .next_on_next_line
    );

endmodule

/* source/line_reader.sv */
`timescale 1ns/1ns

module line_reader import fetch_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       flush,
    input  logic       rd_req,
    input  line_addr_t rd_line,
    output logic       rd_busy,
    output logic       rd_done,
    output line_t      rd_data,
    output logic       ar_valid,
    output addr_t      ar_addr,
    input  logic       ar_ready,
    input  logic       r_valid,
    input  line_t      r_data,
    output logic       r_ready
);

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ADDR,
        RD_RESP
    } rd_state_t;

    rd_state_t  state;
    line_addr_t line_q;
    logic       discard;    // Response belongs to a fetch that was redirected away
    logic       resp_done;

    assign resp_done = r_valid && r_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= RD_IDLE;
        end else begin
            case (state)
                RD_IDLE: begin
                    if (rd_req) begin
                        state <= RD_ADDR;
                    end
                end
                RD_ADDR: begin
                    if (ar_ready) begin
                        state <= RD_RESP;
                    end
                end
                RD_RESP: begin
                    if (r_valid) begin
                        state <= RD_IDLE;
                    end
                end
                default: state <= RD_IDLE;
            endcase
        end
    end

    // A redirect cannot cancel the bus transfer, it only hides the result
    always_ff @(posedge clk) begin
        if (rst) begin
            discard <= 1'b0;
        end else if (resp_done) begin
            discard <= 1'b0;
        end else if (flush && state != RD_IDLE) begin
            discard <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_req && state == RD_IDLE) begin
            line_q <= rd_line;
        end
    end

    assign rd_busy  = state != RD_IDLE;
    assign ar_valid = state == RD_ADDR;
    assign ar_addr  = {line_q, {OFFSET_BITS{1'b0}}};  // Always line aligned
    assign r_ready  = state == RD_RESP;

    // A flush in the response cycle itself also drops the line
    assign rd_done = resp_done && !discard && !flush;
    assign rd_data = r_data;

endmodule

/* source/parcel_aligner.sv */
`timescale 1ns/1ns

module parcel_aligner import fetch_pkg::*; (
    input  line_t                  line,
    input  logic [OFFSET_BITS-1:0] offset,
    output logic                   is_compressed,
    output logic                   crosses_line,
    output logic                   bad_length,
    output instr_t                 instr,
    output logic [OFFSET_BITS-1:0] next_offset,
    output logic                   next_on_next_line
);

    logic [OFFSET_BITS-2:0] pidx;      // Parcel index within the line
    parcel_t                lo_parcel;
    parcel_t                hi_parcel;
    logic [OFFSET_BITS:0]   next_sum;  // Carry out means the next instruction is on the next line

    assign pidx      = offset[OFFSET_BITS-1:1];
    assign lo_parcel = line[pidx*PARCEL_W +: PARCEL_W];

    always_comb begin
        if (pidx == PARCELS_PER_LINE - 1) begin
            hi_parcel = '0;  // Upper half lives in the following line
        end else begin
            hi_parcel = line[(pidx + 1)*PARCEL_W +: PARCEL_W];
        end
    end

    assign is_compressed = lo_parcel[1:0] != 2'b11;
    assign bad_length    = lo_parcel[4:0] == 5'b11111;  // 48-bit and longer encodings
    assign crosses_line  = !is_compressed && pidx == PARCELS_PER_LINE - 1;
    assign instr         = {hi_parcel, lo_parcel};

    assign next_sum = {1'b0, offset} + (is_compressed ? (OFFSET_BITS+1)'(2) : (OFFSET_BITS+1)'(4));
    assign next_offset       = next_sum[OFFSET_BITS-1:0];
    assign next_on_next_line = next_sum[OFFSET_BITS];

endmodule

/* verif/mem_model.sv */
`timescale 1ns/1ns

module mem_model import fetch_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  slow,       // Stretch every response to a long fixed delay
    input  logic  ar_valid,
    output logic  ar_ready,
    input  addr_t ar_addr,
    output logic  r_valid,
    input  logic  r_ready,
    output line_t r_data
);

    integer      seed = 32'h79fa_92c3;
    logic [31:0] rnd;
    logic        busy = 1'b0;    // One read outstanding at most
    addr_t       line_addr;
    logic [5:0]  delay;

    // Content of the halfword at addr, the same rule the testbench reference uses
    function automatic parcel_t parcel_at(input addr_t addr);
        logic [31:0] prod;
        parcel_t     p;
        prod = {1'b0, addr[ALEN-1:1]} * 32'h9e37;
        p = prod[15:0] ^ prod[31:16];  // Folding in the high half varies the length bits
        if ((addr < 32'h8000 || addr > 32'h80ff) && p[4:0] == 5'b11111) begin
            p[0] = 1'b0;  // Illegal lengths exist only in the test window
        end
        return p;
    endfunction

    function automatic line_t line_at(input addr_t addr);
        line_t l;
        for (int i = 0; i < PARCELS_PER_LINE; i++) begin
            l[i*PARCEL_W +: PARCEL_W] = parcel_at(addr + ALEN'(2*i));
        end
        return l;
    endfunction

    initial begin
        ar_ready = 1'b0;
        r_valid  = 1'b0;
        r_data   = '0;
    end

    always @(posedge clk) begin
        rnd = $random(seed);
        if (rst) begin
            ar_ready <= 1'b0;
            r_valid  <= 1'b0;
            busy     <= 1'b0;
            delay    <= '0;
        end else if (!busy) begin
            if (ar_valid && ar_ready) begin
                ar_ready  <= 1'b0;
                busy      <= 1'b1;
                line_addr <= ar_addr;
                delay     <= slow ? 6'd40 : {4'd0, rnd[3:2]};
            end else begin
                ar_ready <= ar_valid && rnd[0];  // Accept the address after a random wait
            end
        end else if (r_valid) begin
            if (r_ready) begin
                r_valid <= 1'b0;
                busy    <= 1'b0;
            end
        end else if (delay == 0) begin
            r_valid <= 1'b1;
            r_data  <= line_at(line_addr);
        end else begin
            delay <= delay - 1'b1;
        end
    end

endmodule

/* verif/tb_ifetch.sv */
`timescale 1ns/1ns

module tb_ifetch import fetch_pkg::*; ();

    logic   clk = 1'b0;
    logic   rst;
    logic   flush;
    addr_t  flush_pc;
    logic   out_ready;
    logic   out_valid;
    logic   out_exception;
    instr_t out_instr;
    addr_t  out_addr;
    addr_t  out_next_addr;
    logic   ar_valid;
    logic   ar_ready;
    addr_t  ar_addr;
    logic   r_valid;
    logic   r_ready;
    line_t  r_data;
    logic   slow;

    integer seed = 32'h79fa_92c3;
    addr_t  exp_pc = '0;     // Address the next accepted instruction must have
    int     accepted = 0;
    int     ar_count = 0;    // Address handshakes seen on the bus
    int     errors = 0;
    int     mismatches = 0;  // Wrong values seen by the comparing process
    int     errors_at_start = 0;
    int     tests_run = 0;
    int     tests_failed = 0;
    instr_t e_instr;
    addr_t  e_next;
    logic   e_exc;

    always #2 clk = ~clk;

    ifetch_top ifetch_top_i (
        .clk, .rst, .flush, .flush_pc,
        .out_valid, .out_ready, .out_instr, .out_addr, .out_next_addr, .out_exception,
        .ar_valid, .ar_ready, .ar_addr, .r_valid, .r_ready, .r_data
    );

    mem_model mem_model_i (
        .clk, .rst, .slow,
        .ar_valid, .ar_ready, .ar_addr, .r_valid, .r_ready, .r_data
    );

    // One instruction of the expected stream, straight from the memory rule
    function automatic void ref_step(input addr_t pc, output instr_t instr,
                                     output addr_t next_pc, output logic exc);
        parcel_t lo;
        parcel_t hi;
        lo = mem_model_i.parcel_at(pc);
        hi = mem_model_i.parcel_at(pc + 32'd2);
        exc = lo[4:0] == 5'b11111;
        if (lo[1:0] != 2'b11) begin
            instr   = {16'h0000, lo};
            next_pc = pc + 32'd2;
        end else begin
            instr   = {hi, lo};
            next_pc = pc + 32'd4;
        end
    endfunction

    // Instructions up to and including the first illegal one, 0 if the window is left first
    function automatic int steps_to_exception(input addr_t start);
        addr_t  pc;
        addr_t  nxt;
        instr_t ins;
        logic   exc;
        int     n;
        pc = start;
        n = 0;
        exc = 1'b0;
        while (!exc && pc >= 32'h8000 && pc < 32'h8100) begin
            ref_step(pc, ins, nxt, exc);
            pc = nxt;
            n++;
        end
        return exc ? n : 0;
    endfunction

    always @(posedge clk) begin
        if (!rst && ar_valid && ar_ready) begin
            ar_count <= ar_count + 1;
        end
        if (!rst && out_valid && out_ready) begin
            ref_step(exp_pc, e_instr, e_next, e_exc);
            if (out_addr !== exp_pc) begin
                $display("Fail at %0t ns: out_addr %h, expected %h", $time, out_addr, exp_pc);
                mismatches <= mismatches + 1;
            end else if (out_exception !== e_exc) begin
                $display("Fail at %0t ns: out_exception %b at %h, expected %b",
                         $time, out_exception, out_addr, e_exc);
                mismatches <= mismatches + 1;
            end else if (!e_exc && out_instr !== e_instr) begin
                $display("Fail at %0t ns: out_instr %h at %h, expected %h",
                         $time, out_instr, out_addr, e_instr);
                mismatches <= mismatches + 1;
            end else if (!e_exc && out_next_addr !== e_next) begin
                $display("Fail at %0t ns: out_next_addr %h at %h, expected %h",
                         $time, out_next_addr, out_addr, e_next);
                mismatches <= mismatches + 1;
            end
            exp_pc   <= e_next;
            accepted <= accepted + 1;
        end
    end

    task automatic redirect(input addr_t pc);
        @(posedge clk);
        out_ready <= 1'b0;  // The decoder takes nothing in the flush cycle
        flush     <= 1'b1;
        flush_pc  <= pc;
        @(posedge clk);
        flush    <= 1'b0;
        exp_pc   <= pc;
        accepted <= 0;
    endtask

    task automatic wait_accepted(input int n, input int limit, input logic random_ready);
        int          cycles;
        logic [31:0] rnd;
        cycles = 0;
        while (accepted < n && cycles < limit) begin
            @(posedge clk);
            rnd = $random(seed);
            out_ready <= random_ready ? rnd[0] : 1'b1;
            cycles++;
        end
        if (accepted < n) begin
            $display("Timeout: only %0d of %0d instructions accepted in %0d cycles",
                     accepted, n, limit);
            errors = errors + 1;
        end
    endtask

    // Hold the output until the unit stalls with the bus idle
    task automatic wait_quiet(input int limit);
        int cycles;
        cycles = 0;
        while (!(out_valid && !ar_valid && !r_ready) && cycles < limit) begin
            @(posedge clk);
            out_ready <= 1'b0;
            cycles++;
        end
        if (!(out_valid && !ar_valid && !r_ready)) begin
            $display("Timeout: the unit did not settle with the bus idle");
            errors = errors + 1;
        end
    endtask

    task automatic start_test();
        errors_at_start = errors + mismatches;
        tests_run++;
    endtask

    task automatic finish_test(input string name);
        if (errors + mismatches != errors_at_start) begin
            tests_failed++;
            $display("Test %0d (%s) failed", tests_run, name);
        end else begin
            $display("Test %0d (%s) passed", tests_run, name);
        end
    endtask

    initial begin
        addr_t pc;
        int    base;
        int    n;
        int    tries;
        int    bad_cycles;
        rst       = 1'b1;
        flush     = 1'b0;
        flush_pc  = '0;
        out_ready = 1'b0;
        slow      = 1'b0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        start_test();
        redirect(32'h1000);
        wait_accepted(200, 5000, 1'b0);
        finish_test("200 instructions from 0x1000");

        start_test();
        pc = 32'h2006;
        tries = 0;
        while (mem_model_i.parcel_at(pc) % 4 != 3 && tries < 256) begin
            pc += 32'd8;  // Stay on the last parcel of each line
            tries++;
        end
        if (tries == 256) begin
            $display("No 32-bit parcel found at offset 6 above 0x2000");
            errors = errors + 1;
        end
        redirect(pc);
        wait_accepted(5, 1000, 1'b0);
        finish_test("instruction crossing a line");

        // The lower lines of the first test are evicted by the lines past 0x1200
        start_test();
        wait_quiet(2000);
        base = ar_count;
        redirect(32'h1100);
        wait_accepted(30, 1000, 1'b0);
        if (ar_count != base) begin
            $display("%0d bus reads for lines that were already cached", ar_count - base);
            errors = errors + 1;
        end
        finish_test("refetch from the cache");

        start_test();
        redirect(32'h2400);
        wait_accepted(150, 8000, 1'b1);
        finish_test("random back-pressure");

        start_test();
        wait_quiet(2000);
        slow <= 1'b1;
        base = ar_count;
        redirect(32'h4000);
        tries = 0;
        while (ar_count == base && tries < 500) begin
            @(posedge clk);
            tries++;
        end
        if (ar_count == base) begin
            $display("Timeout: the read for 0x4000 never reached the bus");
            errors = errors + 1;
        end
        redirect(32'h3000);  // Lands while the slow read is still pending
        wait_accepted(10, 4000, 1'b0);
        slow <= 1'b0;
        finish_test("redirect during a pending read");

        start_test();
        pc = '0;
        for (int i = 0; i < 128 && pc == 0; i++) begin
            if (steps_to_exception(32'h8000 + 2*i) > 0) begin
                pc = 32'h8000 + 2*i;
            end
        end
        if (pc == 0) begin
            $display("No illegal parcel is reachable in 0x8000-0x80ff");
            errors = errors + 1;
        end else begin
            n = steps_to_exception(pc);
            redirect(pc);
            wait_accepted(n, 2000, 1'b0);
            bad_cycles = 0;
            for (int i = 0; i < 50; i++) begin
                @(posedge clk);
                out_ready <= 1'b1;
                if (out_valid) begin
                    bad_cycles++;
                end
            end
            if (bad_cycles != 0 || accepted != n) begin
                $display("Output continued for %0d cycles after the illegal instruction",
                         bad_cycles);
                errors = errors + 1;
            end
        end
        finish_test("halt on illegal length");

        $display("Tests: %0d run, %0d failed, %0d check errors", tests_run, tests_failed,
                 errors + mismatches);
        if (errors + mismatches == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule
